//--- cfgtag_pkg.sv
`default_nettype none

// shared widths, depths, reset values and types for the configuration-tag
// to network path
package cfgtag_pkg;

  // width of the sequence id carried at the head of every serial frame
  localparam int tag_id_width = 4;

  // payload width, also the width of one network word
  localparam int cfg_data_width = 32;

  // a serial frame is the id followed by the payload, MSB first
  localparam int frame_width = tag_id_width + cfg_data_width;

  // credits granted by the receiver, equal to its buffer depth
  localparam int net_credits = 4;

  // wide enough to hold every value from 0 up to net_credits
  localparam int credit_cnt_width = 3;

  // the node powers up holding this id and the gateway expects it,
  // so the two agree right after reset and the gateway locks at once
  localparam logic [tag_id_width-1:0] tag_id_reset = '1;

  // one assembled frame as held by the node
  typedef struct packed {
    logic [tag_id_width-1:0]   id;
    logic [cfg_data_width-1:0] data;
  } cfgtag_word_t;

  // gateway sync machine, sync_lost only leaves through reset
  typedef enum logic [1:0] {
    sync_wait,
    sync_locked,
    sync_lost
  } sync_state_e;

  // word handed to the network port, the id is stripped off
  typedef struct packed {
    logic [cfg_data_width-1:0] data;
  } net_flit_t;

endpackage

`default_nettype wire

//--- cfgtag_node.sv
`timescale 1ns/10ps
`default_nettype none

// serial configuration node
// bits arrive MSB first with the id in front, one bit per cfg_en_i strobe.
// once a full frame is in, it is copied to tag_word_o, which then stays
// put until the next frame completes
module cfgtag_node (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    cfg_bit_i,
  input  logic                    cfg_en_i,
  output cfgtag_pkg::cfgtag_word_t tag_word_o
);

  // counts bits already taken in the current frame, 0 to frame_width-1
  typedef logic [$clog2(cfgtag_pkg::frame_width)-1:0] bit_cnt_t;

  // the bit that completes a frame goes straight to the output register,
  // so the shift register only needs to keep the bits before it
  logic [cfgtag_pkg::frame_width-2:0] shift_r;
  bit_cnt_t                           bit_cnt_r;
  cfgtag_pkg::cfgtag_word_t           tag_word_r;
  logic                               frame_done;

  // high on the strobe that carries the last bit of a frame
  assign frame_done = cfg_en_i && (bit_cnt_r == bit_cnt_t'(cfgtag_pkg::frame_width - 1));

  // serial data path, its contents mean nothing until a frame is counted in
  always_ff @(posedge clk) begin
    if (cfg_en_i) begin
      shift_r <= {shift_r[cfgtag_pkg::frame_width-3:0], cfg_bit_i};
    end
  end

  // bit position within the frame
  always_ff @(posedge clk) begin
    if (reset) begin
      bit_cnt_r <= '0;
    end else if (frame_done) begin
      bit_cnt_r <= '0;
    end else if (cfg_en_i) begin
      bit_cnt_r <= bit_cnt_r + 1'b1;
    end
  end

  // held tagged word
  // it starts at the reset id with zero data so the gateway sees
  // its own expected id and locks without sending anything
  always_ff @(posedge clk) begin
    if (reset) begin
      tag_word_r.id   <= cfgtag_pkg::tag_id_reset;
      tag_word_r.data <= '0;
    end else if (frame_done) begin
      // id sits in the upper bits because it was shifted in first
      tag_word_r <= {shift_r, cfg_bit_i};
    end
  end

  // the gateway samples this level every cycle and relies on it staying
  // unchanged between frames to forward each word once only
  assign tag_word_o = tag_word_r;

endmodule

`default_nettype wire

//--- credit_counter.sv
`timescale 1ns/10ps
`default_nettype none

// tracks words sent to the receiver and not yet credited back
// up_i is the send pulse, down_i the credit pulse from the receiver
module credit_counter (
  input  logic clk,
  input  logic reset,
  input  logic up_i,
  input  logic down_i,
  output logic credit_avail_o
);

  logic [cfgtag_pkg::credit_cnt_width-1:0] count_r;

  // a send and a credit in the same cycle cancel out
  always_ff @(posedge clk) begin
    if (reset) begin
      count_r <= '0;
    end else if (up_i && !down_i) begin
      count_r <= count_r + 1'b1;
    end else if (down_i && !up_i) begin
      count_r <= count_r - 1'b1;
    end
  end

  // only the level leaves this block, the gateway never sees the count
  assign credit_avail_o =
    count_r < (cfgtag_pkg::credit_cnt_width)'(cfgtag_pkg::net_credits);

  // the gateway must hold back once every credit is used
  no_overflow_a: assert property (@(posedge clk) disable iff (reset)
    !(up_i && !down_i && count_r == (cfgtag_pkg::credit_cnt_width)'(cfgtag_pkg::net_credits)));

  // the receiver returns a credit only for a word it actually held
  no_underflow_a: assert property (@(posedge clk) disable iff (reset)
    !(down_i && !up_i && count_r == '0));

endmodule

`default_nettype wire

//--- cfgtag_gateway.sv
`timescale 1ns/10ps
`default_nettype none

// forwards each new tagged word to the network exactly once
// a word counts as new when its id is one past the last id sent.
// the node holds its word as a level, so the same word is seen
// on many cycles and only the id step tells old from new
module cfgtag_gateway (
  input  logic                     clk,
  input  logic                     reset,
  input  cfgtag_pkg::cfgtag_word_t tag_word_i,
  input  logic                     credit_avail_i,
  output logic                     net_valid_o,
  output cfgtag_pkg::net_flit_t    net_flit_o,
  output logic                     sync_lost_o
);

  // id of the last word sent, or the reset id before anything went out
  logic [cfgtag_pkg::tag_id_width-1:0] exp_id_r;
  logic [cfgtag_pkg::tag_id_width-1:0] exp_id_n;
  logic [cfgtag_pkg::tag_id_width-1:0] next_id;
  cfgtag_pkg::sync_state_e             sync_r;
  cfgtag_pkg::sync_state_e             sync_n;
  logic                                new_word;
  logic                                same_word;

  // the id field wraps modulo 16 on its own
  assign next_id = exp_id_r + 1'b1;

  assign same_word = (tag_word_i.id == exp_id_r);

  // a fresh word is waiting, whether or not a credit exists yet
  assign new_word = (sync_r == cfgtag_pkg::sync_locked) && (tag_word_i.id == next_id);

  // without a credit the word just waits in the node
  assign net_valid_o = new_word && credit_avail_i;

  // payload goes straight through, the id stays behind
  assign net_flit_o.data = tag_word_i.data;

  // the expected id only moves when a word really left,
  // so a stalled word is still recognised as new later on
  assign exp_id_n = net_valid_o ? next_id : exp_id_r;

  // sync machine
  always_comb begin
    sync_n = sync_r;
    unique case (sync_r)
      cfgtag_pkg::sync_wait: begin
        // right after reset node and gateway hold the same id
        if (same_word) begin
          sync_n = cfgtag_pkg::sync_locked;
        end
      end
      cfgtag_pkg::sync_locked: begin
        // anything but the old word or its successor means a frame was
        // lost or overwritten, and there is no safe way to resume
        if (!(same_word || new_word)) begin
          sync_n = cfgtag_pkg::sync_lost;
        end
      end
      default: begin
        // sync_lost holds until reset
        sync_n = sync_r;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      exp_id_r <= cfgtag_pkg::tag_id_reset;
      sync_r   <= cfgtag_pkg::sync_wait;
    end else begin
      exp_id_r <= exp_id_n;
      sync_r   <= sync_n;
    end
  end

  assign sync_lost_o = (sync_r == cfgtag_pkg::sync_lost);

  // a held word leaves once only, while the node keeps the same word
  // the cycle after a send nothing may go out again
  once_only_a: assert property (@(posedge clk) disable iff (reset)
    net_valid_o |=> !(net_valid_o && $stable(tag_word_i)));

endmodule

`default_nettype wire

//--- net_rx_fifo.sv
`timescale 1ns/10ps
`default_nettype none

// network side receive buffer
// holds up to net_credits words, shows the head word combinationally
// and returns one credit pulse, a cycle late, for every word popped
module net_rx_fifo (
  input  logic                                clk,
  input  logic                                reset,
  input  logic                                wr_i,
  input  cfgtag_pkg::net_flit_t               wr_flit_i,
  input  logic                                pop_i,
  output logic                                credit_o,
  output logic                                rd_valid_o,
  output logic [cfgtag_pkg::cfg_data_width-1:0] rd_data_o
);

  // depth is a power of two, so the pointers wrap by themselves
  typedef logic [$clog2(cfgtag_pkg::net_credits)-1:0] ptr_t;

  cfgtag_pkg::net_flit_t                   mem [cfgtag_pkg::net_credits];
  ptr_t                                    wr_ptr_r;
  ptr_t                                    rd_ptr_r;
  logic [cfgtag_pkg::credit_cnt_width-1:0] count_r;
  logic                                    not_empty;
  logic                                    do_pop;

  assign not_empty = (count_r != '0);

  // a pop on an empty buffer is dropped and earns no credit
  assign do_pop = pop_i && not_empty;

  // storage
  always_ff @(posedge clk) begin
    if (wr_i) begin
      mem[wr_ptr_r] <= wr_flit_i;
    end
  end

  // pointers and occupancy, write and pop may share a cycle
  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr_r <= '0;
      rd_ptr_r <= '0;
      count_r  <= '0;
    end else begin
      if (wr_i) begin
        wr_ptr_r <= wr_ptr_r + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_r <= rd_ptr_r + 1'b1;
      end
      if (wr_i && !do_pop) begin
        count_r <= count_r + 1'b1;
      end else if (do_pop && !wr_i) begin
        count_r <= count_r - 1'b1;
      end
    end
  end

  // credit goes back to the sender the cycle after the pop
  always_ff @(posedge clk) begin
    if (reset) begin
      credit_o <= 1'b0;
    end else begin
      credit_o <= do_pop;
    end
  end

  assign rd_valid_o = not_empty;
  assign rd_data_o  = mem[rd_ptr_r].data;

  // the credit loop must keep the sender from writing into a full buffer
  no_write_full_a: assert property (@(posedge clk) disable iff (reset)
    !(wr_i && count_r == (cfgtag_pkg::credit_cnt_width)'(cfgtag_pkg::net_credits)));

endmodule

`default_nettype wire

//--- cfgtag_net_top.sv
`timescale 1ns/10ps
`default_nettype none

// serial configuration chain to network port
// node -> gateway -> receive buffer, with the credit counter closing
// the loop from the buffer back to the gateway
module cfgtag_net_top (
  input  logic        clk,
  input  logic        reset,
  input  logic        cfg_bit_i,
  input  logic        cfg_en_i,
  input  logic        rx_pop_i,
  output logic        rx_valid_o,
  output logic [31:0] rx_data_o,
  output logic        sync_lost_o
);

  cfgtag_pkg::cfgtag_word_t tag_word;
  cfgtag_pkg::net_flit_t    net_flit;
  logic                     net_valid;
  logic                     credit;
  logic                     credit_avail;

  cfgtag_node node_i (
    .clk        (clk),
    .reset      (reset),
    .cfg_bit_i  (cfg_bit_i),
    .cfg_en_i   (cfg_en_i),
    .tag_word_o (tag_word)
  );

  cfgtag_gateway gateway_i (
    .clk            (clk),
    .reset          (reset),
    .tag_word_i     (tag_word),
    .credit_avail_i (credit_avail),
    .net_valid_o    (net_valid),
    .net_flit_o     (net_flit),
    .sync_lost_o    (sync_lost_o)
  );

  // sends count up, returned credits count down
  credit_counter credit_i (
    .clk            (clk),
    .reset          (reset),
    .up_i           (net_valid),
    .down_i         (credit),
    .credit_avail_o (credit_avail)
  );

  net_rx_fifo rx_fifo_i (
    .clk        (clk),
    .reset      (reset),
    .wr_i       (net_valid),
    .wr_flit_i  (net_flit),
    .pop_i      (rx_pop_i),
    .credit_o   (credit),
    .rd_valid_o (rx_valid_o),
    .rd_data_o  (rx_data_o)
  );

endmodule

`default_nettype wire

//--- tb_clock_gen.sv
`timescale 1ns/10ps
`default_nettype none

// free running 20 ns clock and the power-on reset
// reset covers the first two rising edges and drops on a falling edge
module tb_clock_gen (
  output logic clk_o,
  output logic reset_o
);

  initial begin
    clk_o = 1'b0;
    forever begin
      #10 clk_o = ~clk_o;
    end
  end

  initial begin
    reset_o = 1'b1;
    repeat (2) @(posedge clk_o);
    @(negedge clk_o);
    reset_o = 1'b0;
  end

endmodule

`default_nettype wire

//--- tb_checker.sv
`timescale 1ns/10ps
`default_nettype none

// watches the consumer side of the DUT
// every word taken with rx_pop_i is compared against the head of the
// expected queue, which the stimulus side fills from its model
module tb_checker (
  input logic        clk_i,
  input logic        reset_i,
  input logic        rx_valid_i,
  input logic [31:0] rx_data_i,
  input logic        rx_pop_i,
  input logic        sync_lost_i
);

  logic [31:0] exp_q [$];
  logic [31:0] exp_word;
  // data_errors only grows in the watch block, other_errors only in the tasks
  int unsigned data_errors = 0;
  int unsigned other_errors = 0;
  int unsigned words_checked = 0;
  int unsigned rows_run = 0;
  int unsigned rows_failed = 0;
  int unsigned last_total = 0;

  task automatic push_expected(input logic [31:0] data);
    exp_q.push_back(data);
  endtask

  function automatic int unsigned expected_left();
    return exp_q.size();
  endfunction

  function automatic int unsigned error_total();
    return data_errors + other_errors;
  endfunction

  // a word leaves the buffer on any edge where it is valid and popped,
  // values are taken before the edge updates the buffer
  always @(posedge clk_i) begin
    if (!reset_i && rx_valid_i && rx_pop_i) begin
      if (exp_q.size() == 0) begin
        $display("CHECK FAILED at time %0t: rx_valid_o expected 0 got 1, data 0x%08h",
                 $time, rx_data_i);
        data_errors++;
      end else begin
        exp_word = exp_q.pop_front();
        words_checked++;
        if (rx_data_i !== exp_word) begin
          $display("CHECK FAILED at time %0t: rx_data_o expected 0x%08h got 0x%08h",
                   $time, exp_word, rx_data_i);
          data_errors++;
        end
      end
    end
  end

  // called at the end of each row, sync_lost_o is a register output and
  // is stable on the falling edge
  task automatic end_row(input int row, input logic [3:0] id, input logic exp_lost);
    int unsigned total;
    if (sync_lost_i !== exp_lost) begin
      $display("CHECK FAILED at time %0t: sync_lost_o expected %0b got %0b",
               $time, exp_lost, sync_lost_i);
      other_errors++;
    end
    total = data_errors + other_errors;
    rows_run++;
    if (total == last_total) begin
      $display("row %0d (id %0d): ok", row, id);
    end else begin
      $display("row %0d (id %0d): %0d errors", row, id, total - last_total);
      rows_failed++;
    end
    last_total = total;
  endtask

  // anything still queued was promised by the model but never showed up
  task automatic close_report();
    if (exp_q.size() != 0) begin
      $display("%0d expected words were never delivered at rx_data_o", exp_q.size());
      other_errors++;
    end
    $display("rows run %0d, rows failed %0d, words checked %0d, errors %0d",
             rows_run, rows_failed, words_checked, data_errors + other_errors);
  endtask

endmodule

`default_nettype wire

//--- tb_top.sv
`timescale 1ns/10ps
`default_nettype none

// top of the testbench
// each table row sends one serial frame and then idles with rx_pop_i held
// at the row's level. a small model of the gateway decides which words
// have to come out of the receive buffer and when sync is lost
module tb_top;

  // one stimulus row
  // a data of zero asks for a random payload, fwd says a credit is free
  // when the frame lands, rst pulses reset before the frame
  typedef struct packed {
    logic        rst;
    logic [3:0]  id;
    logic [31:0] data;
    logic [7:0]  idle;
    logic        pop;
    logic        fwd;
  } row_t;

  // model of the gateway, a stalled word waits in pend_data
  typedef struct packed {
    cfgtag_pkg::sync_state_e state;
    logic [3:0]              exp_id;
    logic                    pend_valid;
    logic [31:0]             pend_data;
  } model_t;

  logic        clk;
  logic        por_reset;
  logic        tb_reset;
  logic        dut_reset;
  logic        cfg_bit;
  logic        cfg_en;
  logic        rx_pop;
  logic        rx_valid;
  logic [31:0] rx_data;
  logic        sync_lost;
  logic [31:0] rand_state;
  model_t      model;
  row_t        rows [24];
  bit          timed_out;

  assign dut_reset = por_reset | tb_reset;

  tb_clock_gen clk_gen (
    .clk_o   (clk),
    .reset_o (por_reset)
  );

  cfgtag_net_top UUT (
    .clk         (clk),
    .reset       (dut_reset),
    .cfg_bit_i   (cfg_bit),
    .cfg_en_i    (cfg_en),
    .rx_pop_i    (rx_pop),
    .rx_valid_o  (rx_valid),
    .rx_data_o   (rx_data),
    .sync_lost_o (sync_lost)
  );

  tb_checker chk (
    .clk_i       (clk),
    .reset_i     (dut_reset),
    .rx_valid_i  (rx_valid),
    .rx_data_i   (rx_data),
    .rx_pop_i    (rx_pop),
    .sync_lost_i (sync_lost)
  );

  // linear congruential generator for the random payloads
  function automatic logic [31:0] next_random();
    rand_state = rand_state * 32'd1103515245 + 32'd12345;
    return rand_state;
  endfunction

  task automatic load_table();
    // in-order frames with the buffer drained as words arrive,
    // row 2 idles long so a repeated word would be caught
    rows[0]  = '{1'b0, 4'd0,  32'h0,        8'd4,  1'b1, 1'b1};
    rows[1]  = '{1'b0, 4'd1,  32'h12345678, 8'd4,  1'b1, 1'b1};
    rows[2]  = '{1'b0, 4'd2,  32'h0,        8'd60, 1'b1, 1'b1};
    rows[3]  = '{1'b0, 4'd3,  32'h0,        8'd2,  1'b1, 1'b1};
    // four words fill the buffer, the fifth stalls and leaves once popping starts
    rows[4]  = '{1'b0, 4'd4,  32'h0,        8'd2,  1'b0, 1'b1};
    rows[5]  = '{1'b0, 4'd5,  32'h0,        8'd2,  1'b0, 1'b1};
    rows[6]  = '{1'b0, 4'd6,  32'h0,        8'd2,  1'b0, 1'b1};
    rows[7]  = '{1'b0, 4'd7,  32'h0,        8'd2,  1'b0, 1'b1};
    rows[8]  = '{1'b0, 4'd8,  32'hcafe0008, 8'd20, 1'b0, 1'b0};
    rows[9]  = '{1'b0, 4'd9,  32'h0,        8'd4,  1'b1, 1'b1};
    // a stalled word overwritten by the next frame loses sync for good
    rows[10] = '{1'b0, 4'd10, 32'h0,        8'd2,  1'b0, 1'b1};
    rows[11] = '{1'b0, 4'd11, 32'h0,        8'd2,  1'b0, 1'b1};
    rows[12] = '{1'b0, 4'd12, 32'h0,        8'd2,  1'b0, 1'b1};
    rows[13] = '{1'b0, 4'd13, 32'h0,        8'd2,  1'b0, 1'b1};
    rows[14] = '{1'b0, 4'd14, 32'h0,        8'd4,  1'b0, 1'b0};
    rows[15] = '{1'b0, 4'd15, 32'h0,        8'd4,  1'b0, 1'b0};
    rows[16] = '{1'b0, 4'd14, 32'h0,        8'd8,  1'b1, 1'b1};
    rows[17] = '{1'b0, 4'd0,  32'h0,        8'd8,  1'b1, 1'b1};
    // reset restores forwarding, then id 3 after id 1 is a skip
    rows[18] = '{1'b1, 4'd0,  32'h0,        8'd4,  1'b1, 1'b1};
    rows[19] = '{1'b0, 4'd1,  32'h0,        8'd4,  1'b1, 1'b1};
    rows[20] = '{1'b0, 4'd3,  32'h0,        8'd4,  1'b1, 1'b1};
    rows[21] = '{1'b0, 4'd2,  32'h0,        8'd4,  1'b1, 1'b1};
    rows[22] = '{1'b1, 4'd0,  32'h0,        8'd4,  1'b1, 1'b1};
    rows[23] = '{1'b0, 4'd1,  32'hdeadbeef, 8'd4,  1'b1, 1'b1};
  endtask

  // node and gateway both start at the reset id, so the gateway locks at once
  task automatic reset_model();
    model.state      = cfgtag_pkg::sync_locked;
    model.exp_id     = cfgtag_pkg::tag_id_reset;
    model.pend_valid = 1'b0;
    model.pend_data  = '0;
  endtask

  // a stalled word goes out as soon as popping returns a credit
  task automatic release_pending();
    if (model.pend_valid && model.state != cfgtag_pkg::sync_lost) begin
      chk.push_expected(model.pend_data);
      model.exp_id     = model.exp_id + 4'd1;
      model.pend_valid = 1'b0;
    end
  endtask

  // sequence rule applied to the word that replaces the held one
  task automatic predict_frame(input logic [3:0] id, input logic [31:0] data,
                               input logic fwd);
    logic [3:0] next_id;
    next_id = model.exp_id + 4'd1;
    if (model.state != cfgtag_pkg::sync_lost) begin
      if (id == model.exp_id) begin
        model.pend_valid = 1'b0;
      end else if (id == next_id && fwd) begin
        chk.push_expected(data);
        model.exp_id     = next_id;
        model.pend_valid = 1'b0;
      end else if (id == next_id) begin
        model.pend_valid = 1'b1;
        model.pend_data  = data;
      end else begin
        model.state      = cfgtag_pkg::sync_lost;
        model.pend_valid = 1'b0;
      end
    end
  endtask

  // one bit per strobe, MSB first so the id goes out ahead of the payload
  task automatic send_frame(input logic [3:0] id, input logic [31:0] data);
    cfgtag_pkg::cfgtag_word_t word;
    word.id   = id;
    word.data = data;
    for (int i = cfgtag_pkg::frame_width - 1; i >= 0; i--) begin
      cfg_bit = word[i];
      cfg_en  = 1'b1;
      @(negedge clk);
    end
    cfg_bit = 1'b0;
    cfg_en  = 1'b0;
  endtask

  task automatic pulse_reset();
    tb_reset = 1'b1;
    repeat (2) @(negedge clk);
    tb_reset = 1'b0;
    reset_model();
  endtask

  // the first falling edge comes after the clock generator has raised reset
  task automatic wait_reset_release(output bit ok);
    int unsigned cycles;
    cycles = 0;
    do begin
      @(negedge clk);
      cycles++;
    end while (por_reset !== 1'b0 && cycles < 16);
    ok = (por_reset === 1'b0);
    if (!ok) begin
      $display("timeout: power-on reset never went low");
    end
  endtask

  // with popping on, every promised word has to come out within a few cycles
  task automatic wait_drain(output bit ok);
    int unsigned cycles;
    cycles = 0;
    while (chk.expected_left() != 0 && cycles < 32) begin
      @(negedge clk);
      cycles++;
    end
    ok = (chk.expected_left() == 0);
    if (!ok) begin
      $display("timeout: %0d expected words did not reach rx_data_o in time",
               chk.expected_left());
    end
  endtask

  task automatic finish_run();
    chk.close_report();
    if (timed_out || chk.error_total() != 0) begin
      $display("TEST FAIL");
    end else begin
      $display("TEST PASS");
    end
    $finish;
  endtask

  initial begin
    logic [31:0] payload;
    bit          ok;
    cfg_bit    = 1'b0;
    cfg_en     = 1'b0;
    rx_pop     = 1'b0;
    tb_reset   = 1'b0;
    rand_state = 32'd13;
    timed_out  = 1'b0;
    load_table();
    reset_model();
    wait_reset_release(ok);
    timed_out = !ok;
    for (int r = 0; r < $size(rows) && !timed_out; r++) begin
      payload = (rows[r].data == 32'h0) ? next_random() : rows[r].data;
      if (rows[r].rst) begin
        pulse_reset();
      end
      rx_pop = rows[r].pop;
      if (rows[r].pop) begin
        release_pending();
      end
      predict_frame(rows[r].id, payload, rows[r].fwd);
      send_frame(rows[r].id, payload);
      repeat (rows[r].idle) @(negedge clk);
      if (rows[r].pop) begin
        wait_drain(ok);
        timed_out = !ok;
      end
      if (!timed_out) begin
        chk.end_row(r, rows[r].id, model.state == cfgtag_pkg::sync_lost);
      end
    end
    finish_run();
  end

endmodule

`default_nettype wire

//--- files.f
cfgtag_pkg.sv
cfgtag_node.sv
credit_counter.sv
cfgtag_gateway.sv
net_rx_fifo.sv
cfgtag_net_top.sv
tb_clock_gen.sv
tb_checker.sv
tb_top.sv

//--- Makefile
# Verilator build and run for the configuration-tag network testbench

VERILATOR ?= verilator
TOP       ?= tb_top
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= TEST PASS

SIM  := $(OBJ_DIR)/V$(TOP)
SRCS := $(wildcard *.sv)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# the run fails unless the pass line shows up in the simulator output
run: $(SIM)
	@out="$$($(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
